// ==== cla_pipe_top.f ====
hdl/cla_pkg.sv
hdl/result_pkg.sv
hdl/pg_stage.sv
hdl/carry_stage.sv
hdl/sum_stage.sv
hdl/cla_pipe_top.sv
sim/cla_pipe_assert.sv
sim/cla_pipe_tb.sv

// ==== Bender.yml ====
package:
  name: cla_pipe

dependencies: {}

sources:
  # Packages first, then the stages and the top level
  - files:
      - hdl/cla_pkg.sv
      - hdl/result_pkg.sv
      - hdl/pg_stage.sv
      - hdl/carry_stage.sv
      - hdl/sum_stage.sv
      - hdl/cla_pipe_top.sv

  # Testbench and bound assertions
  - target: simulation
    files:
      - sim/cla_pipe_assert.sv
      - sim/cla_pipe_tb.sv

// ==== sim/cla_pipe_tb.sv ====
`timescale 1ns/1ps

module cla_pipe_tb
    import cla_pkg::*;
    import result_pkg::*;
();

    localparam int LATENCY        = 3;
    localparam int RESET_CYCLES   = 16;
    localparam int RANDOM_CYCLES  = 500; // Per random phase, two phases
    localparam int TIMEOUT_CYCLES = 1300;

    typedef struct packed {
        data_t sum;
        logic  carry_out;
        logic  ovf;
        logic  uvf;
    } result_t;

    logic  clk;
    logic  rst_n;
    logic  in_valid;
    data_t a;
    data_t b;
    logic  sat_en;
    logic  out_valid;
    data_t sum;
    logic  carry_out;
    logic  ovf;
    logic  uvf;

    result_t     exp_q[$];
    int          edge_q[$];  // Clock edge that sampled each operation
    result_t     expected;
    int          sample_edge;
    int          cycle_cnt    = 0;
    int          checks       = 0;
    int          value_errors = 0;
    int          other_errors = 0;
    data_t       hold_sum     = '0;  // Last result, held while out_valid is low
    logic        hold_carry   = 1'b0;
    logic [15:0] lfsr_state   = 16'd68;
    logic [7:0]  rnd_a;
    logic [7:0]  rnd_b;
    logic [7:0]  rnd_ctl;

    cla_pipe_top uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .a         (a),
        .b         (b),
        .sat_en    (sat_en),
        .out_valid (out_valid),
        .sum       (sum),
        .carry_out (carry_out),
        .ovf       (ovf),
        .uvf       (uvf)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // Signed sum decides the flags, unsigned 9-bit sum gives sum and carry
    function automatic result_t ref_add(input data_t x, input data_t y, input logic sat);
        result_t    r;
        int         total;
        logic [8:0] wide;
        total       = int'($signed(x)) + int'($signed(y));
        wide        = {1'b0, x} + {1'b0, y};
        r.sum       = wide[7:0];
        r.carry_out = wide[8];
        r.ovf       = (total > 127);
        r.uvf       = (total < -128);
        if (sat && r.ovf)
            r.sum = SAT_MAX;
        else if (sat && r.uvf)
            r.sum = SAT_MIN;
        return r;
    endfunction

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0])
            n = n ^ 16'hB400;
        return n;
    endfunction

    task automatic take_bits(input int n, output logic [7:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            v          = {v[6:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
        checks++;
        if (exp_v !== act_v)
        begin
            value_errors++;
            $display("error at %0t ns: %s expected 0x%0h actual 0x%0h",
                     $time, name, exp_v, act_v);
        end
    endtask

    // Called right after a rising edge, DUT samples on the next one
    task automatic drive_op(input data_t x, input data_t y, input logic sat);
        in_valid <= 1'b1;
        a        <= x;
        b        <= y;
        sat_en   <= sat;
        exp_q.push_back(ref_add(x, y, sat));
        edge_q.push_back(cycle_cnt + 2); // Count still holds the previous edge here
        @(posedge clk);
    endtask

    task automatic idle_cycles(input int n);
        in_valid <= 1'b0;
        repeat (n) @(posedge clk);
    endtask

    task automatic report_and_finish();
        $display("checks %0d, value errors %0d, other errors %0d",
                 checks, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    endtask

    // Outputs settle after the rising edge, so look at them on the falling one
    always @(negedge clk)
    begin
        if (!rst_n)
        begin
            check_value("out_valid", 0, out_valid);
            check_value("ovf", 0, ovf);
            check_value("uvf", 0, uvf);
            check_value("sum", 0, sum);
            check_value("carry_out", 0, carry_out);
        end
        else if (out_valid)
        begin
            if (exp_q.size() == 0)
            begin
                other_errors++;
                $display("out_valid at %0t ns with no operation outstanding", $time);
            end
            else
            begin
                expected    = exp_q.pop_front();
                sample_edge = edge_q.pop_front();
                check_value("sum", expected.sum, sum);
                check_value("carry_out", expected.carry_out, carry_out);
                check_value("ovf", expected.ovf, ovf);
                check_value("uvf", expected.uvf, uvf);
                // Result is taken at the next rising edge
                check_value("latency", LATENCY, cycle_cnt + 1 - sample_edge);
                hold_sum   = expected.sum;
                hold_carry = expected.carry_out;
            end
        end
        else
        begin
            check_value("ovf", 0, ovf); // Flags qualified by out_valid
            check_value("uvf", 0, uvf);
            check_value("sum", hold_sum, sum);
            check_value("carry_out", hold_carry, carry_out);
        end
    end

    initial
    begin
        wait (cycle_cnt >= TIMEOUT_CYCLES);
        other_errors++;
        $display("timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
        report_and_finish();
    end

    initial
    begin
        rst_n    = 1'b0;
        in_valid = 1'b0;
        a        = '0;
        b        = '0;
        sat_en   = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        idle_cycles(3);

        // Overflow, wrapped then clamped
        drive_op(8'd100, 8'd100, 1'b0);
        drive_op(8'd100, 8'd100, 1'b1);
        drive_op(8'd127, 8'd1, 1'b0);
        drive_op(8'd127, 8'd1, 1'b1);
        drive_op(8'd127, 8'd127, 1'b1);
        // Underflow, -128 + -1 and -100 + -100
        drive_op(8'h80, 8'hFF, 1'b0);
        drive_op(8'h80, 8'hFF, 1'b1);
        drive_op(8'h9C, 8'h9C, 1'b0);
        drive_op(8'h9C, 8'h9C, 1'b1);
        drive_op(8'h80, 8'h80, 1'b1);
        // Mixed signs never flag
        drive_op(8'd50, 8'hEC, 1'b1);
        drive_op(8'h80, 8'd127, 1'b1);
        drive_op(8'hFF, 8'd1, 1'b0);
        drive_op(8'h00, 8'h00, 1'b1);
        // Spaced operations with the mode flipping
        idle_cycles(2);
        drive_op(8'h90, 8'h90, 1'b1);
        idle_cycles(1);
        drive_op(8'h90, 8'h90, 1'b0);
        idle_cycles(4);
        drive_op(8'd64, 8'd64, 1'b1);
        drive_op(8'd64, 8'd64, 1'b0);
        idle_cycles(3);

        // Wrap mode, valid about three cycles in four
        for (int i = 0; i < RANDOM_CYCLES; i++)
        begin
            take_bits(2, rnd_ctl);
            if (rnd_ctl != 0)
            begin
                take_bits(8, rnd_a);
                take_bits(8, rnd_b);
                drive_op(rnd_a, rnd_b, 1'b0);
            end
            else
                idle_cycles(1);
        end

        // Mode picked at random per operation
        for (int i = 0; i < RANDOM_CYCLES; i++)
        begin
            take_bits(2, rnd_ctl);
            if (rnd_ctl != 0)
            begin
                take_bits(8, rnd_a);
                take_bits(8, rnd_b);
                take_bits(1, rnd_ctl);
                drive_op(rnd_a, rnd_b, rnd_ctl[0]);
            end
            else
                idle_cycles(1);
        end

        in_valid <= 1'b0;
        for (int i = 0; i < 2 * LATENCY + 2 && exp_q.size() != 0; i++)
            @(posedge clk);
        repeat (2) @(posedge clk); // Catch a stray out_valid
        if (exp_q.size() != 0)
        begin
            other_errors++;
            $display("%0d operations never produced a result", exp_q.size());
        end
        report_and_finish();
    end

endmodule

// ==== sim/cla_pipe_assert.sv ====
`timescale 1ns/1ps

module cla_pipe_assert
    import cla_pkg::*;
    import result_pkg::*;
(
    input logic  clk,
    input logic  rst_n,
    input logic  in_valid,
    input logic  sat_en,
    input logic  out_valid,
    input data_t sum,
    input logic  ovf,
    input logic  uvf
);

    // Three register stages between input and output
    assert property (@(posedge clk) disable iff (!rst_n) in_valid |-> ##3 out_valid)
        else $error("out_valid missing 3 cycles after in_valid");

    assert property (@(posedge clk) disable iff (!rst_n) out_valid |-> $past(in_valid, 3))
        else $error("out_valid without in_valid 3 cycles earlier");

    assert property (@(posedge clk) disable iff (!rst_n) !(ovf && uvf))
        else $error("ovf and uvf high together");

    // Clamp follows the mode sampled with the operands
    assert property (@(posedge clk) disable iff (!rst_n)
                     ovf && $past(in_valid && sat_en, 3) |-> sum == SAT_MAX)
        else $error("saturated overflow did not give the largest positive value");

endmodule

bind cla_pipe_top cla_pipe_assert u_assert (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .sat_en    (sat_en),
    .out_valid (out_valid),
    .sum       (sum),
    .ovf       (ovf),
    .uvf       (uvf)
);

// ==== hdl/cla_pipe_top.sv ====
`timescale 1ns/1ps

module cla_pipe_top
    import cla_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  in_valid,
    input  data_t a,
    input  data_t b,
    input  logic  sat_en,
    output logic  out_valid,
    output data_t sum,
    output logic  carry_out,
    output logic  ovf,
    output logic  uvf
);

    // Stage 1 outputs
    logic   s1_valid;
    pg_t    s1_p;
    pg_t    s1_g;
    pg_t    s1_t;
    logic   s1_a_sign;
    logic   s1_b_sign;
    logic   s1_sat;

    // Stage 2 outputs
    logic   s2_valid;
    pg_t    s2_t;
    carry_t s2_c;
    logic   s2_a_sign;
    logic   s2_b_sign;
    logic   s2_sat;

    pg_stage u_pg (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .a         (a),
        .b         (b),
        .sat_en    (sat_en),
        .s1_valid  (s1_valid),
        .s1_p      (s1_p),
        .s1_g      (s1_g),
        .s1_t      (s1_t),
        .s1_a_sign (s1_a_sign),
        .s1_b_sign (s1_b_sign),
        .s1_sat    (s1_sat)
    );

    carry_stage u_carry (
        .clk       (clk),
        .rst_n     (rst_n),
        .s1_valid  (s1_valid),
        .s1_p      (s1_p),
        .s1_g      (s1_g),
        .s1_t      (s1_t),
        .s1_a_sign (s1_a_sign),
        .s1_b_sign (s1_b_sign),
        .s1_sat    (s1_sat),
        .s2_valid  (s2_valid),
        .s2_t      (s2_t),
        .s2_c      (s2_c),
        .s2_a_sign (s2_a_sign),
        .s2_b_sign (s2_b_sign),
        .s2_sat    (s2_sat)
    );

    sum_stage u_sum (
        .clk       (clk),
        .rst_n     (rst_n),
        .s2_valid  (s2_valid),
        .s2_t      (s2_t),
        .s2_c      (s2_c),
        .s2_a_sign (s2_a_sign),
        .s2_b_sign (s2_b_sign),
        .s2_sat    (s2_sat),
        .out_valid (out_valid),
        .sum       (sum),
        .carry_out (carry_out),
        .ovf       (ovf),
        .uvf       (uvf)
    );

endmodule

// ==== hdl/sum_stage.sv ====
`timescale 1ns/1ps

module sum_stage
    import cla_pkg::*;
    import result_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   s2_valid,
    input  pg_t    s2_t,
    input  carry_t s2_c,
    input  logic   s2_a_sign,
    input  logic   s2_b_sign,
    input  logic   s2_sat,
    output logic   out_valid,
    output data_t  sum,
    output logic   carry_out,
    output logic   ovf,
    output logic   uvf
);

    data_t raw_sum;
    data_t sat_sum;
    logic  ovf_next;
    logic  uvf_next;

    assign raw_sum = s2_t ^ s2_c[DATA_W-1:0]; // Each bit takes the carry from below

    // Two positives that come out negative
    assign ovf_next = (s2_a_sign == SIGN_POS) && (s2_b_sign == SIGN_POS)
                   && (raw_sum[SIGN_BIT] == SIGN_NEG);

    // Two negatives that come out positive
    assign uvf_next = (s2_a_sign == SIGN_NEG) && (s2_b_sign == SIGN_NEG)
                   && (raw_sum[SIGN_BIT] == SIGN_POS);

    // Clamp only when the operation asked for it
    always_comb
    begin
        sat_sum = raw_sum;
        if (s2_sat && ovf_next)
        begin
            sat_sum = SAT_MAX;
        end
        else if (s2_sat && uvf_next)
        begin
            sat_sum = SAT_MIN;
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            out_valid <= 1'b0;
            sum       <= '0;
            carry_out <= 1'b0;
            ovf       <= 1'b0;
            uvf       <= 1'b0;
        end
        else
        begin
            out_valid <= s2_valid;
            // Flags only ever high alongside out_valid
            ovf       <= s2_valid & ovf_next;
            uvf       <= s2_valid & uvf_next;
            if (s2_valid) // Sum and carry hold between results
            begin
                sum       <= sat_sum;
                carry_out <= s2_c[DATA_W]; // Ninth bit of the unsigned sum
            end
        end
    end

endmodule

// ==== hdl/carry_stage.sv ====
`timescale 1ns/1ps

module carry_stage
    import cla_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   s1_valid,
    input  pg_t    s1_p,
    input  pg_t    s1_g,
    input  pg_t    s1_t,
    input  logic   s1_a_sign,
    input  logic   s1_b_sign,
    input  logic   s1_sat,
    output logic   s2_valid,
    output pg_t    s2_t,
    output carry_t s2_c,
    output logic   s2_a_sign,
    output logic   s2_b_sign,
    output logic   s2_sat
);

    carry_t c_next;

    // No external carry-in on this adder
    assign c_next[0] = 1'b0;

    // Flattened lookahead, two logic levels per carry
    //   c[i] = g[i-1] | p[i-1]&g[i-2] | ... | p[i-1]..p[1]&g[0]
    // The p..p&c0 term is dropped because c0 is zero
    for (genvar i = 1; i < CARRY_W; i++)
    begin : g_carry
        logic [i-1:0] term;

        for (genvar j = 0; j < i; j++)
        begin : g_term
            if (j == i - 1)
            begin : g_top
                assign term[j] = s1_g[j]; // Generated right below this carry
            end
            else
            begin : g_chain
                // Generated at j, propagated through every bit above it
                assign term[j] = s1_g[j] & (&s1_p[i-1:j+1]);
            end
        end

        assign c_next[i] = |term;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            s2_valid  <= 1'b0;
            s2_t      <= '0;
            s2_c      <= '0;
            s2_a_sign <= 1'b0;
            s2_b_sign <= 1'b0;
            s2_sat    <= 1'b0;
        end
        else
        begin
            s2_valid <= s1_valid;
            if (s1_valid)
            begin
                s2_t      <= s1_t; // Forwarded for the final XOR
                s2_c      <= c_next;
                s2_a_sign <= s1_a_sign;
                s2_b_sign <= s1_b_sign;
                s2_sat    <= s1_sat;
            end
        end
    end

endmodule

// ==== hdl/pg_stage.sv ====
`timescale 1ns/1ps

module pg_stage
    import cla_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  in_valid,
    input  data_t a,
    input  data_t b,
    input  logic  sat_en,
    output logic  s1_valid,
    output pg_t   s1_p,
    output pg_t   s1_g,
    output pg_t   s1_t,
    output logic  s1_a_sign,
    output logic  s1_b_sign,
    output logic  s1_sat
);

    pg_t p_next;
    pg_t g_next;
    pg_t t_next;

    // Propagate taken as OR, still correct since g covers the 1+1 case
    assign p_next = a | b;
    assign g_next = a & b;
    assign t_next = a ^ b; // Half sum

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            s1_valid  <= 1'b0;
            s1_p      <= '0;
            s1_g      <= '0;
            s1_t      <= '0;
            s1_a_sign <= 1'b0;
            s1_b_sign <= 1'b0;
            s1_sat    <= 1'b0;
        end
        else
        begin
            s1_valid <= in_valid;
            if (in_valid) // Payload only moves with a valid operation
            begin
                s1_p      <= p_next;
                s1_g      <= g_next;
                s1_t      <= t_next;
                s1_a_sign <= a[SIGN_BIT];
                s1_b_sign <= b[SIGN_BIT];
                s1_sat    <= sat_en; // Mode sampled with the operands
            end
        end
    end

endmodule

// ==== hdl/result_pkg.sv ====
package result_pkg;

    import cla_pkg::*;

    // Largest positive two's-complement value, 0111_1111
    localparam data_t SAT_MAX = {1'b0, {(DATA_W-1){1'b1}}};

    // Most negative value, 1000_0000
    localparam data_t SAT_MIN = {1'b1, {(DATA_W-1){1'b0}}};

    // Value of the sign bit for each polarity
    localparam logic SIGN_POS = 1'b0;
    localparam logic SIGN_NEG = 1'b1;

endpackage

// ==== hdl/cla_pkg.sv ====
package cla_pkg;

    // Operand width of the adder
    localparam int DATA_W = 8;

    // Carries c0 through c8
    localparam int CARRY_W = DATA_W + 1;

    // Two's-complement sign position
    localparam int SIGN_BIT = DATA_W - 1;

    // Operand or sum word
    typedef logic [DATA_W-1:0] data_t;

    // Full carry chain, c0 at bit 0
    typedef logic [CARRY_W-1:0] carry_t;

    // Per-bit propagate, generate or half sum
    typedef logic [DATA_W-1:0] pg_t;

endpackage
